//--- common/board_pkg.sv
// shared types and widths for the board memory path
// host bus request, bridge-to-controller request and controller states
// referenced by scoped names from the RTL and the testbench

package board_pkg;

   // ************************************************************
   // widths
   // ************************************************************
   parameter int ADDR_W = 21;                  // word address, byte 0 dropped
   parameter int DATA_W = 16;                  // one memory word

   // ************************************************************
   // host side request, held with bus_stb
   // ************************************************************
   typedef struct packed {
      logic              we;                   // 1 = write
      logic [1:0]        sel;                  // byte select, bit 1 upper byte
      logic [ADDR_W-1:0] addr;                 // word address
      logic [DATA_W-1:0] wdata;                // write data
   } bus_req_t;

   // ************************************************************
   // controller request, pulses last one cycle
   // ************************************************************
   typedef struct packed {
      logic              rd;                   // read pulse
      logic              wr;                   // write pulse
      logic [1:0]        be;                   // byte enable, active high
      logic [ADDR_W-1:0] addr;                 // word address
      logic [DATA_W-1:0] wdata;                // write data
   } mem_req_t;

   // controller sequencing
   typedef enum logic [1:0] {
      ST_INIT = 2'd0,                          // init countdown after reset
      ST_IDLE = 2'd1,                          // ready, waiting for a pulse
      ST_BUSY = 2'd2                           // access latency running
   } ctrl_state_t;

endpackage

//--- design/board_reset.sv
// reset shaper for the memory controller
// host memory-reset request is synchronised, then the release is held
// back a few clocks so a short glitch never restarts the controller

module board_reset (
   input  logic clk_p,
   input  logic arst_n,
   input  logic mem_reset,                     // host request, active high
   output logic mem_rst_n                      // controller reset, active low
);

   logic [1:0] req_sync;                       // two-stage synchroniser
   logic [1:0] dly_cnt;                        // release delay
   logic       rst_n_q;

   // ************************************************************
   // synchroniser and release counter
   // ************************************************************
   always_ff @(posedge clk_p or negedge arst_n) begin
      if (!arst_n) begin
         req_sync <= 2'b00;
         dly_cnt  <= 2'd0;
         rst_n_q  <= 1'b0;                     // controller held at once
      end else begin
         req_sync <= {req_sync[0], mem_reset};
         if (req_sync[1]) begin                // request still active
            rst_n_q <= 1'b0;
            dly_cnt <= 2'd0;                   // restart delay
         end else if (dly_cnt != 2'd3) begin
            dly_cnt <= dly_cnt + 2'd1;         // counting out the delay
         end else begin
            rst_n_q <= 1'b1;                   // delay done, release
         end
      end
   end

   assign mem_rst_n = rst_n_q;

endmodule

//--- sdram_bridge/sdram_bridge.sv
// host bus to memory controller bridge
// a held bus strobe becomes one read or write pulse, byte masks are
// latched with the pulse, and the controller ack is delayed two clocks
// and qualified by the strobe before it goes back to the host

module sdram_bridge (
   input  logic                          clk_p,
   input  logic                          arst_n,
   input  logic                          bus_stb,    // level held by host
   input  board_pkg::bus_req_t           bus_req,    // stable while bus_stb
   output logic                          bus_ack,    // one cycle, only with stb
   output logic [board_pkg::DATA_W-1:0]  bus_rdata,  // held read data
   output board_pkg::mem_req_t           mem_req,    // pulse request
   input  logic                          mem_ack,    // controller done
   input  logic [board_pkg::DATA_W-1:0]  mem_rdata,  // valid with mem_ack
   output logic                          dqm_hi,     // upper byte mask
   output logic                          dqm_lo      // lower byte mask
);

   logic                          stb_d;           // strobe one clock back
   logic                          stb_rise;        // first cycle of strobe
   logic                          rd_q;            // read pulse
   logic                          wr_q;            // write pulse
   logic [1:0]                    be_q;
   logic [board_pkg::ADDR_W-1:0]  addr_q;
   logic [board_pkg::DATA_W-1:0]  wdata_q;
   logic [1:0]                    dack;            // ack delay line
   logic                          dqm_hi_q;
   logic                          dqm_lo_q;

   assign stb_rise = bus_stb & ~stb_d;

   // ************************************************************
   // request pulses and byte masks
   // ************************************************************
   always_ff @(posedge clk_p or negedge arst_n) begin
      if (!arst_n) begin
         stb_d    <= 1'b0;
         rd_q     <= 1'b0;
         wr_q     <= 1'b0;
         dqm_hi_q <= 1'b0;
         dqm_lo_q <= 1'b0;
      end else begin
         stb_d <= bus_stb;
         rd_q  <= stb_rise & ~bus_req.we;      // one cycle only
         wr_q  <= stb_rise & bus_req.we;
         if (stb_rise) begin
            // read is always whole word, write masks the unselected bytes
            dqm_hi_q <= bus_req.we & ~bus_req.sel[1];
            dqm_lo_q <= bus_req.we & ~bus_req.sel[0];
         end
      end
   end

   // payload, taken with the pulse
   always_ff @(posedge clk_p) begin
      if (stb_rise) begin
         be_q    <= bus_req.sel;
         addr_q  <= bus_req.addr;
         wdata_q <= bus_req.wdata;
      end
   end

   assign mem_req = '{rd: rd_q, wr: wr_q, be: be_q, addr: addr_q, wdata: wdata_q};
   assign dqm_hi  = dqm_hi_q;
   assign dqm_lo  = dqm_lo_q;

   // ************************************************************
   // acknowledge delay and read data hold
   // ************************************************************
   always_ff @(posedge clk_p or negedge arst_n) begin
      if (!arst_n) begin
         dack <= 2'b00;
      end else begin
         dack[0] <= bus_stb & mem_ack;         // drop ack if host gave up
         dack[1] <= bus_stb & dack[0];
      end
   end

   always_ff @(posedge clk_p) begin
      if (mem_ack) begin
         bus_rdata <= mem_rdata;               // held until next ack
      end
   end

   assign bus_ack = bus_stb & dack[1];

endmodule

//--- sdram_bridge/mem_ctrl.sv
// memory controller model behind the bridge
// counts out an init period after reset, then serves one word access
// at a time with a fixed latency from an internal array
// write merges enabled bytes, read returns the full word
// latency must be at least 2

module mem_ctrl #(
   parameter int MEM_LATENCY = 4,              // request pulse to ack
   parameter int INIT_CYCLES = 20,             // init countdown length
   parameter int MEM_WORDS   = 256             // array depth
) (
   input  logic                          clk_p,
   input  logic                          mem_rst_n,  // from reset shaper
   input  board_pkg::mem_req_t           mem_req,
   output logic                          mem_ack,    // one cycle pulse
   output logic [board_pkg::DATA_W-1:0]  mem_rdata,  // valid with mem_ack
   output logic                          mem_ready   // init done
);

   localparam int CNT_MAX = (INIT_CYCLES > MEM_LATENCY) ? INIT_CYCLES : MEM_LATENCY;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);
   localparam int IDX_W   = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   board_pkg::ctrl_state_t        state;
   logic [CNT_W-1:0]              cnt;         // init and latency countdown
   logic                          take;        // request accepted
   logic                          fire;        // access happens this edge
   logic                          wr_q;        // held access type
   logic [1:0]                    be_q;
   logic [IDX_W-1:0]              idx_q;
   logic [board_pkg::DATA_W-1:0]  wdata_q;
   logic [board_pkg::DATA_W-1:0]  mem [MEM_WORDS];  // stands in for the chip

   assign take      = (state == board_pkg::ST_IDLE) & (mem_req.rd | mem_req.wr);
   assign fire      = (state == board_pkg::ST_BUSY) & (cnt == CNT_W'(1));
   assign mem_ready = (state != board_pkg::ST_INIT);

   // ************************************************************
   // state machine
   // ************************************************************
   always_ff @(posedge clk_p or negedge mem_rst_n) begin
      if (!mem_rst_n) begin
         state   <= board_pkg::ST_INIT;
         cnt     <= CNT_W'(INIT_CYCLES - 1);
         mem_ack <= 1'b0;
      end else begin
         mem_ack <= 1'b0;                      // pulse by default
         case (state)
            board_pkg::ST_INIT: begin
               if (cnt == '0) begin
                  state <= board_pkg::ST_IDLE; // init over
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            board_pkg::ST_IDLE: begin
               if (take) begin
                  state <= board_pkg::ST_BUSY;
                  cnt   <= CNT_W'(MEM_LATENCY - 1);
               end
            end
            board_pkg::ST_BUSY: begin
               if (fire) begin
                  state   <= board_pkg::ST_IDLE;
                  mem_ack <= 1'b1;             // lands MEM_LATENCY after pulse
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            default: state <= board_pkg::ST_INIT;
         endcase
      end
   end

   // ************************************************************
   // request hold and word array
   // ************************************************************
   always_ff @(posedge clk_p) begin
      if (take) begin
         wr_q    <= mem_req.wr;
         be_q    <= mem_req.be;
         idx_q   <= IDX_W'(mem_req.addr % MEM_WORDS);  // wraps on depth
         wdata_q <= mem_req.wdata;
      end
      if (fire && wr_q) begin
         if (be_q[1]) mem[idx_q][15:8] <= wdata_q[15:8];  // upper byte
         if (be_q[0]) mem[idx_q][7:0]  <= wdata_q[7:0];   // lower byte
      end
      if (fire && !wr_q) begin
         mem_rdata <= mem[idx_q];              // whole word
      end
   end

endmodule

//--- design/board_top.sv
// memory side of the board adapter
// host bus -> bridge -> memory controller, with the reset shaper
// holding the controller after a host memory-reset request

module board_top #(
   parameter int MEM_LATENCY = 4,              // controller access latency
   parameter int INIT_CYCLES = 20,             // controller init length
   parameter int MEM_WORDS   = 256             // array depth
) (
   input  logic                          clk_p,
   input  logic                          arst_n,
   input  logic                          mem_reset,  // host memory reset
   input  board_pkg::bus_req_t           bus_req,
   input  logic                          bus_stb,
   output logic                          bus_ack,
   output logic [board_pkg::DATA_W-1:0]  bus_rdata,
   output logic                          mem_ready,
   output logic                          dqm_hi,
   output logic                          dqm_lo
);

   logic                          mem_rst_n;   // shaped controller reset
   board_pkg::mem_req_t           mem_req;     // request pulses
   logic                          mem_ack;
   logic [board_pkg::DATA_W-1:0]  mem_rdata;

   // ************************************************************
   // reset shaper
   // ************************************************************
   board_reset u_reset (
      .clk_p     (clk_p),
      .arst_n    (arst_n),
      .mem_reset (mem_reset),
      .mem_rst_n (mem_rst_n)
   );

   // ************************************************************
   // bus bridge and controller
   // ************************************************************
   sdram_bridge u_bridge (
      .clk_p     (clk_p),
      .arst_n    (arst_n),
      .bus_stb   (bus_stb),
      .bus_req   (bus_req),
      .bus_ack   (bus_ack),
      .bus_rdata (bus_rdata),
      .mem_req   (mem_req),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .dqm_hi    (dqm_hi),
      .dqm_lo    (dqm_lo)
   );

   mem_ctrl #(
      .MEM_LATENCY (MEM_LATENCY),
      .INIT_CYCLES (INIT_CYCLES),
      .MEM_WORDS   (MEM_WORDS)
   ) u_ctrl (
      .clk_p     (clk_p),
      .mem_rst_n (mem_rst_n),
      .mem_req   (mem_req),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

endmodule

//--- testbench/board_properties.sv
// concurrent checks on the board top, attached with bind
// covers ack timing, byte masks, reset values and the init window

module board_properties #(
   parameter int MEM_LATENCY = 4               // controller latency
) (
   input logic                clk_p,
   input logic                arst_n,
   input logic                bus_stb,
   input board_pkg::bus_req_t bus_req,
   input logic                bus_ack,
   input logic                mem_ready,
   input logic                dqm_hi,
   input logic                dqm_lo,
   input board_pkg::mem_req_t mem_req
);

   int fail_cnt = 0;                           // failure tally

   // ************************************************************
   // reset and init window
   // ************************************************************
   a_reset_low: assert property (@(posedge clk_p)
      !arst_n |-> !bus_ack && !mem_ready && !dqm_hi && !dqm_lo && !mem_req.rd && !mem_req.wr)
   else begin
      fail_cnt++;
      $error("outputs not low while arst_n is low");
   end

   a_no_ack_init: assert property (@(posedge clk_p) !mem_ready |-> !bus_ack)
   else begin
      fail_cnt++;
      $error("bus_ack high while mem_ready is low");
   end

   // ************************************************************
   // acknowledge timing
   // ************************************************************
   a_ack_delay: assert property (@(posedge clk_p) disable iff (!arst_n)
      $rose(bus_stb) |-> ##(MEM_LATENCY + 3) bus_ack)
   else begin
      fail_cnt++;
      $error("bus_ack missing at strobe edge plus latency plus 3");
   end

   a_ack_exact: assert property (@(posedge clk_p) disable iff (!arst_n)
      bus_ack |-> $past(bus_stb, MEM_LATENCY + 3) && !$past(bus_stb, MEM_LATENCY + 4))
   else begin
      fail_cnt++;
      $error("bus_ack arrived early or late");
   end

   a_ack_with_stb: assert property (@(posedge clk_p) bus_ack |-> bus_stb)
   else begin
      fail_cnt++;
      $error("bus_ack high without bus_stb");
   end

   a_ack_pulse: assert property (@(posedge clk_p) disable iff (!arst_n) bus_ack |=> !bus_ack)
   else begin
      fail_cnt++;
      $error("bus_ack longer than one cycle");
   end

   // ************************************************************
   // byte masks
   // ************************************************************
   a_mask_rd: assert property (@(posedge clk_p) disable iff (!arst_n)
      mem_req.rd |-> !dqm_hi && !dqm_lo)
   else begin
      fail_cnt++;
      $error("byte mask set on a read");
   end

   a_mask_wr: assert property (@(posedge clk_p) disable iff (!arst_n)
      mem_req.wr |-> (dqm_hi == !bus_req.sel[1]) && (dqm_lo == !bus_req.sel[0]))
   else begin
      fail_cnt++;
      $error("byte mask does not match inverted byte select");
   end

   a_mask_hold: assert property (@(posedge clk_p) disable iff (!arst_n)
      !(mem_req.rd || mem_req.wr) |-> $stable({dqm_hi, dqm_lo}))
   else begin
      fail_cnt++;
      $error("byte mask changed without a request");
   end

endmodule

//--- testbench/tb_board.sv
// testbench for the board memory path, plays the host core
// reset, word and byte accesses, memory reset with retention check
// bus timing and masks are watched by the bound properties

module tb_board;

   localparam int MEM_LATENCY = 4;
   localparam int INIT_CYCLES = 20;
   localparam int MEM_WORDS   = 256;
   localparam int WAIT_MAX    = 200;           // cycles per wait loop
   localparam int N_WORDS     = 8;

   logic                         clk_p;
   logic                         arst_n;
   logic                         mem_reset;
   board_pkg::bus_req_t          bus_req;
   logic                         bus_stb;
   logic                         bus_ack;
   logic [board_pkg::DATA_W-1:0] bus_rdata;
   logic                         mem_ready;
   logic                         dqm_hi;
   logic                         dqm_lo;

   logic [31:0]                  lfsr = 32'h50aa;
   logic [15:0]                  shadow [MEM_WORDS];  // expected array contents
   logic [board_pkg::ADDR_W-1:0] addr_list [N_WORDS];
   int                           err_cnt   = 0;
   int                           tests_run = 0;
   int                           tests_bad = 0;
   int                           test_base = 0;

   bind board_top board_properties #(.MEM_LATENCY(MEM_LATENCY)) u_props (
      .clk_p     (clk_p),
      .arst_n    (arst_n),
      .bus_stb   (bus_stb),
      .bus_req   (bus_req),
      .bus_ack   (bus_ack),
      .mem_ready (mem_ready),
      .dqm_hi    (dqm_hi),
      .dqm_lo    (dqm_lo),
      .mem_req   (mem_req)
   );

   board_top #(
      .MEM_LATENCY (MEM_LATENCY),
      .INIT_CYCLES (INIT_CYCLES),
      .MEM_WORDS   (MEM_WORDS)
   ) u_dut (.*);

   initial begin
      clk_p = 1'b0;
      forever #50 clk_p = ~clk_p;              // period 100
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);               // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_p);
      #1;                                      // drive after the edge
   endtask

   // ************************************************************
   // host bus and init helpers
   // ************************************************************
   task automatic check_init();
      int n;
      n = 0;
      while (mem_ready !== 1'b1 && n < WAIT_MAX) begin
         next_cycle();
         n++;
      end
      if (mem_ready !== 1'b1) begin
         $display("mem_ready did not rise within %0d cycles", WAIT_MAX);
         err_cnt++;
      end
      assert (n >= INIT_CYCLES) else begin
         $display("Fail at %0t: mem_ready low cycles got %0d expected >= %0d",
                  $time, n, INIT_CYCLES);
         err_cnt++;
      end
   endtask

   task automatic bus_xfer(input logic we, input logic [1:0] sel,
                           input logic [20:0] addr, input logic [15:0] wdata,
                           output logic [15:0] rdata);
      int n;
      bus_req = '{we: we, sel: sel, addr: addr, wdata: wdata};
      bus_stb = 1'b1;
      n = 0;
      while (bus_ack !== 1'b1 && n < WAIT_MAX) begin
         next_cycle();
         n++;
      end
      rdata = bus_rdata;
      if (bus_ack !== 1'b1) begin
         $display("no bus_ack within %0d cycles at address %h", WAIT_MAX, addr);
         err_cnt++;
      end
      next_cycle();                            // host sees ack on this edge
      bus_stb = 1'b0;
      next_cycle();
   endtask

   task automatic write_word(input logic [20:0] addr, input logic [1:0] sel,
                             input logic [15:0] data);
      logic [15:0] unused;
      int          idx;
      idx = int'(addr) % MEM_WORDS;            // array wraps on depth
      bus_xfer(1'b1, sel, addr, data, unused);
      if (sel[1]) shadow[idx][15:8] = data[15:8];
      if (sel[0]) shadow[idx][7:0] = data[7:0];
   endtask

   task automatic check_read(input logic [20:0] addr);
      logic [15:0] got;
      logic [15:0] exp;
      exp = shadow[int'(addr) % MEM_WORDS];
      bus_xfer(1'b0, 2'b11, addr, 16'h0000, got);
      assert (got === exp) else begin
         $display("Fail at %0t: bus_rdata got %h expected %h", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic pulse_mem_reset();
      int n;
      mem_reset = 1'b1;
      n = 0;
      while (mem_ready !== 1'b0 && n < WAIT_MAX) begin
         next_cycle();
         n++;
      end
      if (mem_ready !== 1'b0) begin
         $display("mem_ready did not drop after mem_reset");
         err_cnt++;
      end
      next_cycle();
      mem_reset = 1'b0;
      check_init();
   endtask

   task automatic end_test(input string name);
      int n;
      n = err_cnt + u_dut.u_props.fail_cnt - test_base;
      tests_run++;
      if (n != 0) tests_bad++;
      $display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "bad", n);
      test_base = err_cnt + u_dut.u_props.fail_cnt;
   endtask

   // ************************************************************
   // test sequence
   // ************************************************************
   initial begin
      logic [31:0] r;
      logic [31:0] s;
      arst_n    = 1'b1;
      mem_reset = 1'b0;
      bus_stb   = 1'b0;
      bus_req   = '0;
      #10 arst_n = 1'b0;
      repeat (16) @(posedge clk_p);
      #1 arst_n = 1'b1;

      check_init();
      end_test("reset_init");

      for (int i = 0; i < N_WORDS; i++) begin
         take_bits(21, r);
         addr_list[i] = r[20:0];
         take_bits(16, r);
         write_word(addr_list[i], 2'b11, r[15:0]);
      end
      for (int i = 0; i < N_WORDS; i++) check_read(addr_list[i]);
      end_test("word_rw");

      for (int i = 0; i < N_WORDS; i++) begin
         take_bits(16, r);
         write_word(addr_list[i], 2'b01, r[15:0]);  // lower byte only
         check_read(addr_list[i]);
         take_bits(16, r);
         write_word(addr_list[i], 2'b10, r[15:0]);  // upper byte only
         check_read(addr_list[i]);
      end
      end_test("byte_rw");

      // mixed selects while the properties watch ack and masks
      for (int i = 0; i < N_WORDS; i++) begin
         take_bits(2, s);
         take_bits(16, r);
         write_word(addr_list[i], s[1:0], r[15:0]);
         check_read(addr_list[i]);
      end
      end_test("ack_mask");

      pulse_mem_reset();
      for (int i = 0; i < N_WORDS; i++) check_read(addr_list[i]);
      end_test("retain");

      $display("tests run %0d, failed %0d, tb errors %0d, assertion errors %0d",
               tests_run, tests_bad, err_cnt, u_dut.u_props.fail_cnt);
      if (tests_bad == 0 && err_cnt == 0 && u_dut.u_props.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- filelist.f
common/board_pkg.sv
design/board_reset.sv
sdram_bridge/sdram_bridge.sv
sdram_bridge/mem_ctrl.sv
design/board_top.sv
testbench/board_properties.sv
testbench/tb_board.sv

//--- run_sim.sh
#!/bin/sh
# build and run the board testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_board \
   -f filelist.f -Mdir obj_dir -o tb_board
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_board +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
   echo "failure reported, see $LOG"
   exit 1
fi
exit 0
